//--- all.f
core_pkg.sv
mem_agu.sv
lsu.sv
dbus_ram.sv
mem_writeback.sv
lsu_top.sv
tb_lsu_top.sv

//--- core_pkg.sv
`default_nettype none

package core_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OFFSET_WIDTH   = 12;
    localparam int BYTE_EN_WIDTH  = DATA_WIDTH / 8;

    // Data RAM defaults
    localparam int DBUS_WAIT_CYCLES = 2;
    localparam int DBUS_DEPTH_WORDS = 256;

    // --------------------
    // Memory op encoding
    // --------------------
    // Mirrors RISC-V funct3; bit 2 selects zero extension
    typedef enum logic [2:0] {
        MEM_LB  = 3'b000,
        MEM_LH  = 3'b001,
        MEM_LW  = 3'b010,
        MEM_LBU = 3'b100,
        MEM_LHU = 3'b101
    } mem_op_t;

    // Access size in bits 1:0 of the op
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    typedef enum logic [1:0] {
        EXC_NONE             = 2'd0,
        EXC_LOAD_MISALIGNED  = 2'd1,
        EXC_STORE_MISALIGNED = 2'd2
    } exc_cause_t;

    // --------------------
    // Stage records
    // --------------------
    typedef struct packed {
        logic                      is_load;
        logic                      is_store;
        mem_op_t                   funct3;
        logic [DATA_WIDTH-1:0]     base;
        logic [OFFSET_WIDTH-1:0]   offset;
        logic [DATA_WIDTH-1:0]     store_data;
        logic [REG_ADDR_WIDTH-1:0] rd;
    } ex_req_t;

    typedef struct packed {
        logic                      read;
        logic                      write;
        mem_op_t                   op;
        logic [DATA_WIDTH-1:0]     address;
        logic [DATA_WIDTH-1:0]     writedata;
        logic [REG_ADDR_WIDTH-1:0] rd;
    } mem_req_t;

    // Data bus
    typedef struct packed {
        logic                     read;
        logic                     write;
        logic [DATA_WIDTH-1:0]    address;
        logic [DATA_WIDTH-1:0]    writedata;
        logic [BYTE_EN_WIDTH-1:0] byte_enable;
    } avalon_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] readdata;
        logic                  waitrequest;
    } avalon_resp_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0]     data;
    } load_result_t;

    typedef struct packed {
        logic                      load_valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0]     data;
        logic                      exc_valid;
        exc_cause_t                exc_cause;
        logic [DATA_WIDTH-1:0]     exc_addr;
    } wb_t;

endpackage

`default_nettype wire

//--- dbus_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dbus_ram import core_pkg::*; #(
    parameter int WAIT_CYCLES = DBUS_WAIT_CYCLES,
    parameter int DEPTH_WORDS = DBUS_DEPTH_WORDS
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire avalon_req_t dbus_req,
    output avalon_resp_t     dbus_resp
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    logic [DATA_WIDTH-1:0] mem [DEPTH_WORDS];
    logic [DATA_WIDTH-1:0] readdata_q;
    logic [CNT_W-1:0]      wait_cnt;
    logic [IDX_W-1:0]      word_idx;
    logic                  bus_active;
    logic                  waitrequest;
    logic                  accept;

    assign bus_active  = dbus_req.read | dbus_req.write;
    assign waitrequest = (wait_cnt != CNT_W'(WAIT_CYCLES));
    assign accept      = bus_active & ~waitrequest;
    assign word_idx    = dbus_req.address[2 +: IDX_W];

    // --------------------
    // Wait state counter
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (accept) begin
            wait_cnt <= '0;
        end else if (bus_active) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // --------------------
    // Word array
    // --------------------
    always_ff @(posedge clk) begin
        if (accept && dbus_req.write) begin
            for (int i = 0; i < BYTE_EN_WIDTH; i++) begin
                if (dbus_req.byte_enable[i]) begin
                    mem[word_idx][8*i +: 8] <= dbus_req.writedata[8*i +: 8];
                end
            end
        end
    end

    // Read data stays until the next accepted read
    always_ff @(posedge clk) begin
        if (accept && dbus_req.read) begin
            readdata_q <= mem[word_idx];
        end
    end

    assign dbus_resp.readdata    = readdata_q;
    assign dbus_resp.waitrequest = waitrequest;

    // Addresses past the array would alias onto low words
    assert property (@(posedge clk) disable iff (rst)
        accept |-> (dbus_req.address[DATA_WIDTH-1:2] < DEPTH_WORDS))
    else $error("dbus_ram: word index 0x%0h out of range",
                dbus_req.address[DATA_WIDTH-1:2]);

endmodule

`default_nettype wire

//--- lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu import core_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire mem_req_t     stage_req,
    output avalon_req_t       dbus_req,
    input  wire avalon_resp_t dbus_resp,
    output logic              stall,
    output load_result_t      load_result,
    output logic              load_misaligned,
    output logic              store_misaligned
);

    logic [2:0]                op_bits;
    logic [1:0]                size;
    logic [1:0]                byte_off;
    logic                      misaligned;
    logic                      read_accept;

    // Captured at read acceptance
    logic                      read_pending;
    logic [1:0]                pend_byte_off;
    logic [2:0]                pend_op;
    logic [REG_ADDR_WIDTH-1:0] pend_rd;

    logic [DATA_WIDTH-1:0]     shifted;
    logic [DATA_WIDTH-1:0]     load_data;
    logic                      sign_bit;

    assign op_bits  = stage_req.op;
    assign size     = op_bits[1:0];
    assign byte_off = stage_req.address[1:0];

    // --------------------
    // Alignment check
    // --------------------
    always_comb begin
        case (size)
            SIZE_HALF: misaligned = byte_off[0];
            SIZE_WORD: misaligned = (byte_off != 2'b00);
            default:   misaligned = 1'b0;
        endcase
    end

    assign load_misaligned  = stage_req.read & misaligned;
    assign store_misaligned = stage_req.write & misaligned;

    // --------------------
    // Bus request
    // --------------------
    assign dbus_req.read    = stage_req.read & ~misaligned;
    assign dbus_req.write   = stage_req.write & ~misaligned;
    assign dbus_req.address = {stage_req.address[DATA_WIDTH-1:2], 2'b00};

    // Store data is copied into every lane, byte enables pick the lane
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                dbus_req.writedata   = {4{stage_req.writedata[7:0]}};
                dbus_req.byte_enable = 4'b0001 << byte_off;
            end
            SIZE_HALF: begin
                dbus_req.writedata   = {2{stage_req.writedata[15:0]}};
                dbus_req.byte_enable = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dbus_req.writedata   = stage_req.writedata;
                dbus_req.byte_enable = 4'b1111;
            end
        endcase
    end

    assign stall       = (dbus_req.read | dbus_req.write) & dbus_resp.waitrequest;
    assign read_accept = dbus_req.read & ~dbus_resp.waitrequest;

    // --------------------
    // Read tracking
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= read_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (read_accept) begin
            pend_byte_off <= byte_off;
            pend_op       <= op_bits;
            pend_rd       <= stage_req.rd;
        end
    end

    // --------------------
    // Read data realign
    // --------------------
    // RAM returns the whole word, move the addressed lane down to bit 0
    assign shifted = dbus_resp.readdata >> {pend_byte_off, 3'b000};

    always_comb begin
        sign_bit  = 1'b0;
        load_data = dbus_resp.readdata;
        case (pend_op[1:0])
            SIZE_BYTE: begin
                sign_bit  = shifted[7] & ~pend_op[2];
                load_data = {{24{sign_bit}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                sign_bit  = shifted[15] & ~pend_op[2];
                load_data = {{16{sign_bit}}, shifted[15:0]};
            end
            default: begin
                load_data = dbus_resp.readdata;
            end
        endcase
    end

    assign load_result.valid = read_pending;
    assign load_result.rd    = pend_rd;
    assign load_result.data  = load_data;

    // Execute stage sends either a load or a store, never both
    assert property (@(posedge clk) disable iff (rst)
        !(stage_req.read && stage_req.write))
    else $error("lsu: read and write both high");

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import core_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire ex_req_t ex_req,
    output logic         stall,
    output wb_t          wb
);

    mem_req_t     stage_req;
    avalon_req_t  dbus_req;
    avalon_resp_t dbus_resp;
    load_result_t load_result;
    logic         load_misaligned;
    logic         store_misaligned;

    // --------------------
    // Input side
    // --------------------
    mem_agu u_mem_agu (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .ex_req    (ex_req),
        .stage_req (stage_req)
    );

    // --------------------
    // Memory access
    // --------------------
    lsu u_lsu (
        .clk              (clk),
        .rst              (rst),
        .stage_req        (stage_req),
        .dbus_req         (dbus_req),
        .dbus_resp        (dbus_resp),
        .stall            (stall),
        .load_result      (load_result),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    dbus_ram #(
        .WAIT_CYCLES (DBUS_WAIT_CYCLES),
        .DEPTH_WORDS (DBUS_DEPTH_WORDS)
    ) u_dbus_ram (
        .clk       (clk),
        .rst       (rst),
        .dbus_req  (dbus_req),
        .dbus_resp (dbus_resp)
    );

    // Output side
    mem_writeback u_mem_writeback (
        .clk              (clk),
        .rst              (rst),
        .load_result      (load_result),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned),
        .fault_addr       (stage_req.address),
        .wb               (wb)
    );

endmodule

`default_nettype wire

//--- mem_agu.sv
`timescale 1ns/1ps
`default_nettype none

module mem_agu import core_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    stall,
    input  wire ex_req_t ex_req,
    output mem_req_t     stage_req
);

    logic [DATA_WIDTH-1:0] offset_ext;
    logic [DATA_WIDTH-1:0] eff_addr;
    mem_req_t              next_req;

    // --------------------
    // Address generation
    // --------------------
    assign offset_ext = {{(DATA_WIDTH-OFFSET_WIDTH){ex_req.offset[OFFSET_WIDTH-1]}},
                         ex_req.offset};
    assign eff_addr   = ex_req.base + offset_ext;

    always_comb begin
        next_req.read      = ex_req.is_load;
        next_req.write     = ex_req.is_store;
        next_req.op        = ex_req.funct3;
        next_req.address   = eff_addr;
        next_req.writedata = ex_req.store_data;
        next_req.rd        = ex_req.rd;
    end

    // --------------------
    // Request register
    // --------------------
    // Held while the bus is busy, the LSU keeps working on it
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_req <= '0;
        end else if (!stall) begin
            stage_req <= next_req;
        end
    end

    // Execute stage holds its request until stall drops
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(ex_req))
    else $error("mem_agu: ex_req changed while stall was high");

endmodule

`default_nettype wire

//--- mem_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module mem_writeback import core_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire load_result_t          load_result,
    input  wire logic                  load_misaligned,
    input  wire logic                  store_misaligned,
    input  wire logic [DATA_WIDTH-1:0] fault_addr,
    output wb_t                        wb
);

    exc_cause_t cause;

    // --------------------
    // Exception cause
    // --------------------
    always_comb begin
        if (load_misaligned) begin
            cause = EXC_LOAD_MISALIGNED;
        end else if (store_misaligned) begin
            cause = EXC_STORE_MISALIGNED;
        end else begin
            cause = EXC_NONE;
        end
    end

    // --------------------
    // Writeback register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.load_valid <= 1'b0;
            wb.exc_valid  <= 1'b0;
        end else begin
            wb.load_valid <= load_result.valid;
            wb.exc_valid  <= load_misaligned | store_misaligned;
        end
    end

    // Payload follows the strobes
    always_ff @(posedge clk) begin
        wb.rd        <= load_result.rd;
        wb.data      <= load_result.data;
        wb.exc_cause <= cause;
        wb.exc_addr  <= fault_addr;
    end

    // One request per stage, so only one misaligned kind at a time
    assert property (@(posedge clk) disable iff (rst)
        !(load_misaligned && store_misaligned))
    else $error("mem_writeback: load and store misaligned together");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top \
    -f all.f -o tb_lsu_top > build.log 2>&1 \
    && ./obj_dir/tb_lsu_top > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error, see build.log and sim.log"
[ -f sim.log ] && cat sim.log
grep -qx "Test OK" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

//--- tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top
    import core_pkg::*;
();

    localparam int WAIT        = DBUS_WAIT_CYCLES;
    localparam int FILL_WORDS  = 32;
    localparam int RAND_OPS    = 48;
    localparam int B2B_PAIRS   = 8;
    localparam int N_OPS       = FILL_WORDS + 2 + RAND_OPS + 6 + 2 * B2B_PAIRS;
    localparam int CYCLE_LIMIT = N_OPS * (WAIT + 3) + 200;

    typedef struct packed {
        int                        due;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0]     data;
    } load_exp_t;

    typedef struct packed {
        int                    due;
        exc_cause_t            cause;
        logic [DATA_WIDTH-1:0] addr;
    } exc_exp_t;

    logic    clk;
    logic    rst;
    ex_req_t ex_req;
    logic    stall;
    wb_t     wb;

    // Byte-wide reference memory over the tested region
    logic [7:0] model_mem [4 * FILL_WORDS];
    load_exp_t  load_q[$];
    exc_exp_t   exc_q[$];
    int         cycle = 0;
    int         errors = 0;
    int         stall_start = 1;
    int         stall_end = 0;

    logic                      exp_load_valid;
    logic [REG_ADDR_WIDTH-1:0] exp_rd;
    logic [DATA_WIDTH-1:0]     exp_data;
    logic                      exp_exc_valid;
    exc_cause_t                exp_cause;
    logic [DATA_WIDTH-1:0]     exp_addr;
    logic                      exp_stall;

    lsu_top DUT (.clk(clk), .rst(rst), .ex_req(ex_req), .stall(stall), .wb(wb));

    always #50 clk = ~clk;

    // --------------------
    // Reference model
    // --------------------
    function automatic void store_to_model(logic [31:0] addr, mem_op_t op, logic [31:0] data);
        logic [6:0] a;
        a = addr[6:0];
        model_mem[a] = data[7:0];
        if (op[1:0] != SIZE_BYTE) model_mem[a + 7'd1] = data[15:8];
        if (op[1:0] == SIZE_WORD) begin
            model_mem[a + 7'd2] = data[23:16];
            model_mem[a + 7'd3] = data[31:24];
        end
    endfunction

    // Bit 2 of the op turns sign extension off
    function automatic logic [31:0] load_from_model(logic [31:0] addr, mem_op_t op);
        logic [6:0]  a;
        logic [31:0] val;
        a = addr[6:0];
        case (op[1:0])
            SIZE_BYTE: val = {{24{model_mem[a][7] & ~op[2]}}, model_mem[a]};
            SIZE_HALF: val = {{16{model_mem[a + 7'd1][7] & ~op[2]}},
                              model_mem[a + 7'd1], model_mem[a]};
            default:   val = {model_mem[a + 7'd3], model_mem[a + 7'd2],
                              model_mem[a + 7'd1], model_mem[a]};
        endcase
        return val;
    endfunction

    function automatic logic is_misaligned(mem_op_t op, logic [31:0] addr);
        return (op[1:0] == SIZE_HALF && addr[0]) || (op[1:0] == SIZE_WORD && addr[1:0] != 2'b00);
    endfunction

    function automatic logic [31:0] fill_value(logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic logic [31:0] random_addr(mem_op_t op);
        logic [31:0] a;
        a = 32'($urandom_range(0, 4 * FILL_WORDS - 1));
        if (op[1:0] == SIZE_HALF) a[0] = 1'b0;
        if (op[1:0] == SIZE_WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic mem_op_t random_op();
        case ($urandom_range(0, 4))
            0:       return MEM_LB;
            1:       return MEM_LH;
            2:       return MEM_LW;
            3:       return MEM_LBU;
            default: return MEM_LHU;
        endcase
    endfunction

    function automatic logic [4:0] random_rd();
        return 5'($urandom_range(1, 31));
    endfunction

    // --------------------
    // Request driver
    // --------------------
    // Starts and ends just after a falling edge
    task automatic issue_access(input logic is_ld, input mem_op_t op, input logic [31:0] addr,
                                input logic [31:0] data, input logic [4:0] rd);
        ex_req_t     req;
        logic [11:0] off;
        int          k;
        load_exp_t   le;
        exc_exp_t    ee;
        off            = 12'($urandom);
        req            = '0;
        req.is_load    = is_ld;
        req.is_store   = !is_ld;
        req.funct3     = op;
        req.offset     = off;
        req.base       = addr - {{20{off[11]}}, off};
        req.store_data = data;
        req.rd         = rd;
        ex_req = req;
        while (stall) @(negedge clk);
        // Captured on the coming rising edge
        k = cycle + 1;
        if (is_misaligned(op, addr)) begin
            ee.due   = k + 1;
            ee.cause = is_ld ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED;
            ee.addr  = addr;
            exc_q.push_back(ee);
        end else begin
            stall_start = k;
            stall_end   = k + WAIT - 1;
            if (is_ld) begin
                le.due  = k + WAIT + 2;
                le.rd   = rd;
                le.data = load_from_model(addr, op);
                load_q.push_back(le);
            end else begin
                store_to_model(addr, op, data);
            end
        end
        @(negedge clk);
        ex_req = '0;
    endtask

    // --------------------
    // Expected outputs
    // --------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        exp_load_valid <= 1'b0;
        exp_exc_valid  <= 1'b0;
        exp_stall      <= !rst && (cycle + 1 >= stall_start) && (cycle + 1 <= stall_end);
        if (!rst && load_q.size() != 0 && load_q[0].due == cycle + 1) begin
            exp_load_valid <= 1'b1;
            exp_rd         <= load_q[0].rd;
            exp_data       <= load_q[0].data;
            void'(load_q.pop_front());
        end
        if (!rst && exc_q.size() != 0 && exc_q[0].due == cycle + 1) begin
            exp_exc_valid <= 1'b1;
            exp_cause     <= exc_q[0].cause;
            exp_addr      <= exc_q[0].addr;
            void'(exc_q.pop_front());
        end
    end

    always @(posedge clk) begin
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // Checks sample on the falling edge, away from the register updates
    assert property (@(negedge clk) disable iff (rst) stall == exp_stall)
    else begin
        errors++;
        $display("ERR %0t stall expected %0b got %0b", $time, exp_stall, stall);
    end
    assert property (@(negedge clk) disable iff (rst) wb.load_valid == exp_load_valid)
    else begin
        errors++;
        $display("ERR %0t wb.load_valid expected %0b got %0b", $time,
                 exp_load_valid, wb.load_valid);
    end
    assert property (@(negedge clk) disable iff (rst) exp_load_valid |-> wb.rd == exp_rd)
    else begin
        errors++;
        $display("ERR %0t wb.rd expected %0d got %0d", $time, exp_rd, wb.rd);
    end
    assert property (@(negedge clk) disable iff (rst) exp_load_valid |-> wb.data == exp_data)
    else begin
        errors++;
        $display("ERR %0t wb.data expected %08h got %08h", $time, exp_data, wb.data);
    end
    assert property (@(negedge clk) disable iff (rst) wb.exc_valid == exp_exc_valid)
    else begin
        errors++;
        $display("ERR %0t wb.exc_valid expected %0b got %0b", $time,
                 exp_exc_valid, wb.exc_valid);
    end
    assert property (@(negedge clk) disable iff (rst) exp_exc_valid |-> wb.exc_cause == exp_cause)
    else begin
        errors++;
        $display("ERR %0t wb.exc_cause expected %0d got %0d", $time, exp_cause, wb.exc_cause);
    end
    assert property (@(negedge clk) disable iff (rst) exp_exc_valid |-> wb.exc_addr == exp_addr)
    else begin
        errors++;
        $display("ERR %0t wb.exc_addr expected %08h got %08h", $time, exp_addr, wb.exc_addr);
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] addr;
        logic [31:0] addr2;
        mem_op_t     op;
        void'($urandom(9062));
        clk    = 1'b0;
        rst    = 1'b1;
        ex_req = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // Quiet period after reset
        repeat (5) @(negedge clk);

        for (int i = 0; i < FILL_WORDS; i++) begin
            issue_access(1'b0, MEM_LW, 32'(4 * i), fill_value(32'(4 * i)), 5'd0);
        end

        // Word round trip
        addr = random_addr(MEM_LW);
        issue_access(1'b0, MEM_LW, addr, $urandom, 5'd0);
        issue_access(1'b1, MEM_LW, addr, 32'd0, random_rd());

        // Mixed sizes and extensions
        for (int i = 0; i < RAND_OPS; i++) begin
            op = random_op();
            issue_access(op[2] | 1'($urandom), op, random_addr(op), $urandom, random_rd());
        end

        // Misaligned accesses, then both words read back
        addr  = random_addr(MEM_LW);
        addr2 = addr ^ 32'h40;
        issue_access(1'b1, MEM_LH, addr | 32'd1, 32'd0, random_rd());
        issue_access(1'b1, MEM_LW, addr | 32'd2, 32'd0, random_rd());
        issue_access(1'b0, MEM_LH, addr2 | 32'd3, $urandom, 5'd0);
        issue_access(1'b0, MEM_LW, addr2 | 32'd1, $urandom, 5'd0);
        issue_access(1'b1, MEM_LW, addr, 32'd0, random_rd());
        issue_access(1'b1, MEM_LW, addr2, 32'd0, random_rd());

        // Load result and next exception land in the same cycle
        for (int i = 0; i < B2B_PAIRS; i++) begin
            op = (i % 2 == 0) ? MEM_LW : MEM_LBU;
            issue_access(1'b1, op, random_addr(op), 32'd0, random_rd());
            issue_access(1'b1, MEM_LW, random_addr(MEM_LW) | 32'd3, 32'd0, random_rd());
        end

        repeat (WAIT + 4) @(negedge clk);
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
